/* design/marble_pkg.sv */
// =========================================================
// Shared register map, SPI frame layout and TMDS symbols for
// the board test build, used by scoped names
// =========================================================
`default_nettype none

package marble_pkg;

	// Register bank geometry
	localparam int REG_ADDR_W = 4;
	localparam int REG_DATA_W = 16;

	// Register map
	localparam logic [REG_ADDR_W-1:0] REG_ID         = 4'd0;
	localparam logic [REG_ADDR_W-1:0] REG_EXT_CONFIG = 4'd1;
	localparam logic [REG_ADDR_W-1:0] REG_LEDS       = 4'd2;
	localparam logic [REG_ADDR_W-1:0] REG_SCRATCH    = 4'd3;

	// Read-only identification word, "MB" in ASCII
	localparam logic [REG_DATA_W-1:0] BOARD_ID = 16'h4d42;

	// Stored widths and ext_config bit assignments
	localparam int EXT_CONFIG_W     = 4;
	localparam int LEDS_W           = 8;
	localparam int EXT_TMDS_EN_BIT  = 0;
	localparam int EXT_VCXO_OFF_BIT = 1;

	// SPI frame is a command byte then one data word, MSB first
	localparam int FRAME_BITS     = 24;
	localparam int CMD_BITS       = 8;
	localparam int FRAME_READ_BIT = 7;

	typedef logic [9:0] tmds_sym_t;

	// Control symbols indexed by {C1, C0}
	localparam tmds_sym_t [3:0] TMDS_CTRL = {
		10'b1010101011,
		10'b0101010100,
		10'b0010101011,
		10'b1101010100
	};

endpackage

`default_nettype wire

/* design/mmc_spi_slave.sv */
// =========================================================
// SPI slave for the board microcontroller, oversampled in clk
// Turns 24-bit frames into register reads and write commands
// =========================================================
`default_nettype none

module mmc_spi_slave (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              sclk,
	input  logic                              csb,
	input  logic                              mosi,
	output logic                              miso,
	output logic [marble_pkg::REG_ADDR_W-1:0] rd_addr,
	input  logic [marble_pkg::REG_DATA_W-1:0] rd_data,
	output logic                              wr_valid,
	output logic [marble_pkg::REG_ADDR_W-1:0] wr_addr,
	output logic [marble_pkg::REG_DATA_W-1:0] wr_data,
	input  logic                              wr_ready
);

	localparam int FRAME_W = marble_pkg::FRAME_BITS;
	localparam int DATA_W  = marble_pkg::REG_DATA_W;
	localparam int CNT_W   = $clog2(FRAME_W + 1);
	// Read flag position once the whole frame is in
	localparam int FRAME_RD_POS = FRAME_W - marble_pkg::CMD_BITS + marble_pkg::FRAME_READ_BIT;

	logic sclk_meta, sclk_sync, sclk_prev;
	logic csb_meta, csb_sync, csb_prev;
	logic mosi_meta, mosi_sync;
	logic sclk_rise, sclk_fall, frame_end, wr_load;
	logic [CNT_W-1:0] bit_cnt;
	logic [FRAME_W-1:0] shift_in;
	logic cmd_load;
	logic [DATA_W-1:0] rd_shift;
	logic miso_bit;

	// Two flop synchronizers, plus one more stage for edge detect
	always_ff @(posedge clk) begin
		if (reset) begin
			{sclk_meta, sclk_sync, sclk_prev} <= 3'b000;
			{csb_meta, csb_sync, csb_prev} <= 3'b111;
			{mosi_meta, mosi_sync} <= 2'b00;
		end else begin
			{sclk_meta, sclk_sync, sclk_prev} <= {sclk, sclk_meta, sclk_sync};
			{csb_meta, csb_sync, csb_prev} <= {csb, csb_meta, csb_sync};
			{mosi_meta, mosi_sync} <= {mosi, mosi_meta};
		end
	end

	assign sclk_rise = sclk_sync & ~sclk_prev & ~csb_sync;
	assign sclk_fall = ~sclk_sync & sclk_prev & ~csb_sync;
	assign frame_end = csb_sync & ~csb_prev;

	// Bit counter saturates so overlong frames never look complete
	always_ff @(posedge clk) begin
		if (reset || csb_sync) begin
			bit_cnt <= '0;
		end else if (sclk_rise && bit_cnt != '1) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sclk_rise) begin
			shift_in <= {shift_in[FRAME_W-2:0], mosi_sync};
		end
	end

	// Command byte sits in the low bits right after the 8th bit
	assign rd_addr = shift_in[marble_pkg::REG_ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_load <= 1'b0;
		end else begin
			cmd_load <= sclk_rise && bit_cnt == CNT_W'(marble_pkg::CMD_BITS - 1);
		end
	end

	// Read data leaves on falling edges, ready for the next rising edge
	always_ff @(posedge clk) begin
		if (reset || csb_sync) begin
			rd_shift <= '0;
			miso_bit <= 1'b0;
		end else if (cmd_load) begin
			rd_shift <= shift_in[marble_pkg::FRAME_READ_BIT] ? rd_data : '0;
		end else if (sclk_fall) begin
			miso_bit <= rd_shift[DATA_W-1];
			rd_shift <= {rd_shift[DATA_W-2:0], 1'b0};
		end
	end

	assign miso = miso_bit & ~csb;

	// Only a complete write frame produces a command
	assign wr_load = frame_end && bit_cnt == CNT_W'(FRAME_W) && !shift_in[FRAME_RD_POS]
		&& (!wr_valid || wr_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_valid <= 1'b0;
		end else if (wr_load) begin
			wr_valid <= 1'b1;
		end else if (wr_ready) begin
			wr_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_load) begin
			wr_addr <= shift_in[DATA_W +: marble_pkg::REG_ADDR_W];
			wr_data <= shift_in[DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* design/config_regs.sv */
// =========================================================
// Register bank behind the SPI slave, with a combinational
// read port and a valid/ready write command port
// =========================================================
`default_nettype none

module config_regs (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [marble_pkg::REG_ADDR_W-1:0]   rd_addr,
	output logic [marble_pkg::REG_DATA_W-1:0]   rd_data,
	input  logic                                wr_valid,
	input  logic [marble_pkg::REG_ADDR_W-1:0]   wr_addr,
	input  logic [marble_pkg::REG_DATA_W-1:0]   wr_data,
	output logic                                wr_ready,
	output logic [marble_pkg::EXT_CONFIG_W-1:0] ext_config,
	output logic [marble_pkg::LEDS_W-1:0]       leds
);

	localparam int DATA_W = marble_pkg::REG_DATA_W;
	localparam int EXT_W  = marble_pkg::EXT_CONFIG_W;
	localparam int LEDS_W = marble_pkg::LEDS_W;

	logic [DATA_W-1:0] scratch;
	logic wr_fire;

	assign wr_fire = wr_valid && wr_ready;

	// Ready drops only while in reset
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ready <= 1'b0;
		end else begin
			wr_ready <= 1'b1;
		end
	end

	// REG_ID and unmapped addresses fall through to default
	always_ff @(posedge clk) begin
		if (reset) begin
			ext_config <= '0;
			leds <= '0;
			scratch <= '0;
		end else if (wr_fire) begin
			case (wr_addr)
				marble_pkg::REG_EXT_CONFIG: ext_config <= wr_data[EXT_W-1:0];
				marble_pkg::REG_LEDS:       leds <= wr_data[LEDS_W-1:0];
				marble_pkg::REG_SCRATCH:    scratch <= wr_data;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (rd_addr)
			marble_pkg::REG_ID:         rd_data = marble_pkg::BOARD_ID;
			marble_pkg::REG_EXT_CONFIG: rd_data = DATA_W'(ext_config);
			marble_pkg::REG_LEDS:       rd_data = DATA_W'(leds);
			marble_pkg::REG_SCRATCH:    rd_data = scratch;
			default:                    rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/tmds_encoder.sv */
// =========================================================
// DVI TMDS 8b/10b encoder with running disparity, one clk of
// latency from de/data/ctrl to the registered symbol
// =========================================================
`default_nettype none

module tmds_encoder (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  de,
	input  logic [7:0]            data,
	input  logic [1:0]            ctrl,
	output marble_pkg::tmds_sym_t sym
);

	logic [3:0] data_ones;
	logic use_xnor;
	logic [8:0] q_m;
	logic [3:0] q_m_ones;
	// Ones minus zeros of q_m[7:0]
	logic signed [5:0] balance;
	logic signed [5:0] disparity;
	logic signed [5:0] disparity_next;
	marble_pkg::tmds_sym_t sym_next;

	function automatic logic [3:0] count_ones(input logic [7:0] v);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < 8; i++) begin
			n = n + 4'(v[i]);
		end
		return n;
	endfunction

	// Stage one picks the chain with fewer transitions
	always_comb begin
		data_ones = count_ones(data);
		use_xnor = (data_ones > 4'd4) || (data_ones == 4'd4 && !data[0]);
		q_m[0] = data[0];
		for (int i = 1; i < 8; i++) begin
			q_m[i] = use_xnor ? (q_m[i-1] ~^ data[i]) : (q_m[i-1] ^ data[i]);
		end
		q_m[8] = ~use_xnor;
	end

	// Stage two steers the running disparity back toward zero
	always_comb begin
		q_m_ones = count_ones(q_m[7:0]);
		balance = $signed({1'b0, q_m_ones, 1'b0}) - 6'sd8;
		if (disparity == 0 || balance == 0) begin
			sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			disparity_next = q_m[8] ? disparity + balance : disparity - balance;
		end else if ((disparity > 0 && balance > 0) || (disparity < 0 && balance < 0)) begin
			sym_next = {1'b1, q_m[8], ~q_m[7:0]};
			disparity_next = disparity - balance + (q_m[8] ? 6'sd2 : 6'sd0);
		end else begin
			sym_next = {1'b0, q_m[8], q_m[7:0]};
			disparity_next = disparity + balance - (q_m[8] ? 6'sd0 : 6'sd2);
		end
	end

	// Blanking sends a control symbol and restarts the balance
	always_ff @(posedge clk) begin
		if (reset) begin
			sym <= marble_pkg::TMDS_CTRL[0];
			disparity <= '0;
		end else if (!de) begin
			sym <= marble_pkg::TMDS_CTRL[ctrl];
			disparity <= '0;
		end else begin
			sym <= sym_next;
			disparity <= disparity_next;
		end
	end

endmodule

`default_nettype wire

/* design/tmds_test.sv */
// =========================================================
// Video timing and colour test pattern driving three TMDS
// data channels, held in blanking while not enabled
// =========================================================
`default_nettype none

module tmds_test #(
	parameter int H_ACTIVE     = 640,
	parameter int H_TOTAL      = 800,
	parameter int V_ACTIVE     = 480,
	parameter int V_TOTAL      = 525,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_LEN   = 96,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_LEN   = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  enable,
	output marble_pkg::tmds_sym_t tmds_sym0,
	output marble_pkg::tmds_sym_t tmds_sym1,
	output marble_pkg::tmds_sym_t tmds_sym2
);

	localparam int X_W = $clog2(H_TOTAL);
	localparam int Y_W = $clog2(V_TOTAL);

	logic [X_W-1:0] x;
	logic [Y_W-1:0] y;
	logic active, hsync, vsync;
	logic de_r, hsync_r, vsync_r;
	logic [7:0] red_r, green_r, blue_r;

	assign active = (x < H_ACTIVE) && (y < V_ACTIVE);
	assign hsync = (x >= H_SYNC_START) && (x < H_SYNC_START + H_SYNC_LEN);
	assign vsync = (y >= V_SYNC_START) && (y < V_SYNC_START + V_SYNC_LEN);

	always_ff @(posedge clk) begin
		if (reset || !enable) begin
			x <= '0;
			y <= '0;
			{de_r, hsync_r, vsync_r} <= 3'b000;
		end else begin
			if (x == H_TOTAL - 1) begin
				x <= '0;
				y <= (y == V_TOTAL - 1) ? '0 : y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
			{de_r, hsync_r, vsync_r} <= {active, hsync, vsync};
		end
	end

	// Pixel registered alongside de and sync
	always_ff @(posedge clk) begin
		red_r <= 8'(x);
		green_r <= 8'(y);
		blue_r <= 8'(x) ^ 8'(y);
	end

	// Sync travels on the blue channel only
	tmds_encoder enc_blue (.clk(clk), .reset(reset), .de(de_r), .data(blue_r),
		.ctrl({vsync_r, hsync_r}), .sym(tmds_sym0));
	tmds_encoder enc_green (.clk(clk), .reset(reset), .de(de_r), .data(green_r),
		.ctrl(2'b00), .sym(tmds_sym1));
	tmds_encoder enc_red (.clk(clk), .reset(reset), .de(de_r), .data(red_r),
		.ctrl(2'b00), .sym(tmds_sym2));

endmodule

`default_nettype wire

/* design/marble_top.sv */
// =========================================================
// Portable core of the board test build: SPI register access,
// LED and VCXO control, and the TMDS test pattern
// =========================================================
`default_nettype none

module marble_top #(
	parameter int H_ACTIVE     = 16,
	parameter int H_TOTAL      = 24,
	parameter int V_ACTIVE     = 6,
	parameter int V_TOTAL      = 9,
	parameter int H_SYNC_START = 18,
	parameter int H_SYNC_LEN   = 3,
	parameter int V_SYNC_START = 7,
	parameter int V_SYNC_LEN   = 1
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          sclk,
	input  logic                          csb,
	input  logic                          mosi,
	output logic                          miso,
	output marble_pkg::tmds_sym_t         tmds_sym0,
	output marble_pkg::tmds_sym_t         tmds_sym1,
	output marble_pkg::tmds_sym_t         tmds_sym2,
	output logic [marble_pkg::LEDS_W-1:0] leds,
	output logic                          vcxo_en
);

	logic [marble_pkg::REG_ADDR_W-1:0] rd_addr;
	logic [marble_pkg::REG_DATA_W-1:0] rd_data;
	logic wr_valid;
	logic wr_ready;
	logic [marble_pkg::REG_ADDR_W-1:0] wr_addr;
	logic [marble_pkg::REG_DATA_W-1:0] wr_data;
	logic [marble_pkg::EXT_CONFIG_W-1:0] ext_config;
	logic tmds_enable;

	assign tmds_enable = ext_config[marble_pkg::EXT_TMDS_EN_BIT];
	// Host may turn off the 20 MHz VCXO
	assign vcxo_en = ~ext_config[marble_pkg::EXT_VCXO_OFF_BIT];

	mmc_spi_slave spi (.clk(clk), .reset(reset), .sclk(sclk), .csb(csb), .mosi(mosi),
		.miso(miso), .rd_addr(rd_addr), .rd_data(rd_data), .wr_valid(wr_valid),
		.wr_addr(wr_addr), .wr_data(wr_data), .wr_ready(wr_ready));

	config_regs regs (.clk(clk), .reset(reset), .rd_addr(rd_addr), .rd_data(rd_data),
		.wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ready(wr_ready),
		.ext_config(ext_config), .leds(leds));

	tmds_test #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
	) tmds (.clk(clk), .reset(reset), .enable(tmds_enable),
		.tmds_sym0(tmds_sym0), .tmds_sym1(tmds_sym1), .tmds_sym2(tmds_sym2));

endmodule

`default_nettype wire

/* verif/marble_tb_asserts.sv */
// ============================================================
// Bound checks for the SPI write handshake, MISO idle level
// and the running disparity of the three TMDS encoders
// ============================================================
`default_nettype none

module marble_tb_asserts (
	input logic                                clk,
	input logic                                reset,
	input logic                                csb,
	input logic                                miso,
	input logic                                wr_valid,
	input logic                                wr_ready,
	input logic [marble_pkg::REG_ADDR_W-1:0]   wr_addr,
	input logic [marble_pkg::REG_DATA_W-1:0]   wr_data,
	input logic signed [5:0]                   disp_blue,
	input logic signed [5:0]                   disp_green,
	input logic signed [5:0]                   disp_red
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Even and within the DC balance window
	function automatic logic disp_ok(input logic signed [5:0] d);
		return !d[0] && d >= -6'sd16 && d <= 6'sd16;
	endfunction

	property hold_until_ready;
		@(posedge clk) disable iff (reset)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data);
	endproperty

	hold_a: assert property (hold_until_ready) else begin
		$error("write command dropped or changed before wr_ready");
		fail_count++;
	end

	miso_idle_a: assert property (@(posedge clk) disable iff (reset) csb |-> !miso) else begin
		$error("miso not low while csb is high");
		fail_count++;
	end

	disp_a: assert property (@(posedge clk) disable iff (reset)
		disp_ok(disp_blue) && disp_ok(disp_green) && disp_ok(disp_red)) else begin
		$error("encoder disparity odd or out of range");
		fail_count++;
	end

endmodule

bind marble_top marble_tb_asserts props (
	.clk(clk), .reset(reset), .csb(csb), .miso(miso),
	.wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr), .wr_data(wr_data),
	.disp_blue(tmds.enc_blue.disparity), .disp_green(tmds.enc_green.disparity),
	.disp_red(tmds.enc_red.disparity)
);

`default_nettype wire

/* verif/marble_tb.sv */
// ============================================================
// Testbench for marble_top: SPI register access, VCXO control
// and a decoded check of the TMDS test pattern
// ============================================================
`default_nettype none

module marble_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACTIVE = 16;
	localparam int H_TOTAL = 24;
	localparam int V_ACTIVE = 6;
	localparam int V_TOTAL = 9;
	// Run budget in clk cycles
	localparam int VIDEO_FRAMES = 4;
	localparam int SPI_FRAMES = 48;
	localparam int TIMEOUT_CYCLES = 8 + VIDEO_FRAMES * V_TOTAL * H_TOTAL + SPI_FRAMES * 300;

	logic clk, reset, sclk, csb, mosi;
	logic miso, vcxo_en;
	logic [7:0] leds;
	marble_pkg::tmds_sym_t sym0, sym1, sym2;
	int seed;
	logic track_en, in_vsync;
	int x_cnt, line_cnt, vsyncs_seen;
	logic [8:0] dec_b, dec_g, dec_r;
	logic [3:0] exp_ext;
	logic [7:0] exp_leds;
	logic [15:0] exp_scratch, wdata, discard;

	marble_top uut (.clk(clk), .reset(reset), .sclk(sclk), .csb(csb), .mosi(mosi),
		.miso(miso), .tmds_sym0(sym0), .tmds_sym1(sym1), .tmds_sym2(sym2),
		.leds(leds), .vcxo_en(vcxo_en));

	always #5 clk = ~clk;

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected) begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// Bit 8 set marks a control symbol, low bits hold the code or the byte
	function automatic logic [8:0] tmds_decode(input marble_pkg::tmds_sym_t s);
		logic [7:0] d;
		logic [7:0] v;
		for (int c = 0; c < 4; c++) begin
			if (s == marble_pkg::TMDS_CTRL[c]) begin
				return {1'b1, 6'd0, 2'(c)};
			end
		end
		d = s[9] ? ~s[7:0] : s[7:0];
		v[0] = d[0];
		for (int i = 1; i < 8; i++) begin
			v[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
		end
		return {1'b0, v};
	endfunction

	function automatic logic [15:0] exp_reg(input logic [3:0] addr);
		case (addr)
			marble_pkg::REG_ID:         return marble_pkg::BOARD_ID;
			marble_pkg::REG_EXT_CONFIG: return 16'(exp_ext);
			marble_pkg::REG_LEDS:       return 16'(exp_leds);
			marble_pkg::REG_SCRATCH:    return exp_scratch;
			default:                    return 16'h0000;
		endcase
	endfunction

	// SPI mode 0 at clk/10, MISO sampled just before each rising sclk
	task automatic spi_xfer(input logic [23:0] frame, input int nbits, output logic [15:0] rd_word);
		rd_word = '0;
		@(posedge clk);
		csb <= 1'b0;
		for (int i = 0; i < nbits; i++) begin
			mosi <= frame[23-i];
			repeat (4) @(posedge clk);
			@(negedge clk);
			if (i >= 8) begin
				rd_word = {rd_word[14:0], miso};
			end
			@(posedge clk);
			sclk <= 1'b1;
			repeat (5) @(posedge clk);
			sclk <= 1'b0;
		end
		repeat (5) @(posedge clk);
		csb <= 1'b1;
		mosi <= 1'b0;
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [15:0] data);
		logic accepted;
		spi_xfer({4'h0, addr, data}, 24, discard);
		accepted = 1'b0;
		for (int n = 0; n < 8 && !accepted; n++) begin
			@(negedge clk);
			accepted = uut.wr_valid && uut.wr_ready;
		end
		if (!accepted) begin
			$display("Write command was not accepted by the register bank within 8 cycles");
			$display("Verification failed");
			$fatal(1);
		end
		@(posedge clk);
		case (addr)
			marble_pkg::REG_EXT_CONFIG: exp_ext = data[3:0];
			marble_pkg::REG_LEDS:       exp_leds = data[7:0];
			marble_pkg::REG_SCRATCH:    exp_scratch = data;
			default: ;
		endcase
		repeat (4) @(posedge clk);
	endtask

	task automatic reg_read_check(input logic [3:0] addr, input string what);
		logic [15:0] got;
		spi_xfer({1'b1, 3'b000, addr, 16'h0000}, 24, got);
		repeat (6) @(posedge clk);
		check_equal(32'(got), 32'(exp_reg(addr)), what);
	endtask

	task automatic check_channels_idle(input string what);
		check_equal(32'(sym0), 32'(marble_pkg::TMDS_CTRL[0]), {what, " blue"});
		check_equal(32'(sym1), 32'(marble_pkg::TMDS_CTRL[0]), {what, " green"});
		check_equal(32'(sym2), 32'(marble_pkg::TMDS_CTRL[0]), {what, " red"});
	endtask

	// Compare process on the decoded symbol stream
	always @(negedge clk) begin
		dec_b = tmds_decode(sym0);
		dec_g = tmds_decode(sym1);
		dec_r = tmds_decode(sym2);
		if (!track_en) begin
			x_cnt = 0;
			line_cnt = 0;
			vsyncs_seen = 0;
			in_vsync = 1'b0;
		end else if (!dec_b[8]) begin
			check_equal(32'({dec_g[8], dec_r[8]}), 32'(0), "data on all channels");
			check_equal(32'(dec_r[7:0]), 32'(x_cnt[7:0]), "red pixel");
			check_equal(32'(dec_g[7:0]), 32'(line_cnt[7:0]), "green pixel");
			check_equal(32'(dec_b[7:0]), 32'(x_cnt[7:0] ^ line_cnt[7:0]), "blue pixel");
			x_cnt++;
		end else begin
			check_equal(32'({dec_g[8], dec_r[8]}), 32'(3), "control on all channels");
			if (x_cnt != 0) begin
				check_equal(32'(x_cnt), 32'(H_ACTIVE), "data symbols per line");
				x_cnt = 0;
				line_cnt++;
			end
			if (dec_b[1] && !in_vsync) begin
				check_equal(32'(line_cnt), 32'(V_ACTIVE), "lines before vsync");
				vsyncs_seen++;
			end else if (!dec_b[1] && in_vsync) begin
				line_cnt = 0;
			end
			in_vsync = dec_b[1];
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$fatal(1);
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		seed = 32'h452c_c8a5;
		track_en = 1'b0;
		exp_ext = '0;
		exp_leds = '0;
		exp_scratch = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);

		reg_read_check(marble_pkg::REG_ID, "board ID after reset");
		@(negedge clk);
		check_equal(32'(leds), 32'(0), "leds after reset");
		check_equal(32'(vcxo_en), 32'(1), "vcxo_en after reset");
		check_channels_idle("TMDS after reset");

		for (int i = 0; i < 6; i++) begin
			wdata = 16'($random(seed));
			reg_write(marble_pkg::REG_LEDS, wdata);
			@(negedge clk);
			check_equal(32'(leds), 32'(wdata[7:0]), "leds port");
			reg_read_check(marble_pkg::REG_LEDS, "leds read-back");
			reg_write(marble_pkg::REG_SCRATCH, 16'($random(seed)));
			reg_read_check(marble_pkg::REG_SCRATCH, "scratch read-back");
		end
		reg_write(marble_pkg::REG_ID, 16'h1234);
		reg_read_check(marble_pkg::REG_ID, "board ID after write");
		reg_read_check(4'd4, "unmapped address 4");
		reg_read_check(4'd9, "unmapped address 9");
		reg_read_check(4'd15, "unmapped address 15");

		// Aborted frames must not write
		// Spare command bits set so a shifted frame still points at the same register
		spi_xfer({4'h3, marble_pkg::REG_SCRATCH, 16'hdead}, 20, discard);
		repeat (8) @(posedge clk);
		spi_xfer({4'h1, marble_pkg::REG_LEDS, 16'h00a5}, 23, discard);
		repeat (8) @(posedge clk);
		reg_read_check(marble_pkg::REG_SCRATCH, "scratch after short frame");
		reg_read_check(marble_pkg::REG_LEDS, "leds after short frame");

		reg_write(marble_pkg::REG_EXT_CONFIG, 16'h0002);
		@(negedge clk);
		check_equal(32'(vcxo_en), 32'(0), "vcxo_en with VCXO off");
		reg_read_check(marble_pkg::REG_EXT_CONFIG, "ext_config read-back");
		reg_write(marble_pkg::REG_EXT_CONFIG, 16'h0000);
		@(negedge clk);
		check_equal(32'(vcxo_en), 32'(1), "vcxo_en restored");

		// Two full frames of pattern
		track_en = 1'b1;
		reg_write(marble_pkg::REG_EXT_CONFIG, 16'h0001);
		wait (vsyncs_seen >= 2);
		track_en = 1'b0;
		reg_write(marble_pkg::REG_EXT_CONFIG, 16'h0000);
		for (int n = 0; n < 8 && !(sym0 == marble_pkg::TMDS_CTRL[0]
			&& sym1 == marble_pkg::TMDS_CTRL[0] && sym2 == marble_pkg::TMDS_CTRL[0]); n++) begin
			@(negedge clk);
		end
		for (int n = 0; n < 2 * H_TOTAL; n++) begin
			@(negedge clk);
			check_channels_idle("TMDS after disable");
		end
		reg_read_check(marble_pkg::REG_EXT_CONFIG, "ext_config after disable");

		if (uut.props.fail_count != 0) begin
			$display("Bound assertions failed %0d times", uut.props.fail_count);
			$display("Verification failed");
			$fatal(1);
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* project.f */
design/marble_pkg.sv
design/mmc_spi_slave.sv
design/config_regs.sv
design/tmds_encoder.sv
design/tmds_test.sv
design/marble_top.sv
verif/marble_tb_asserts.sv
verif/marble_tb.sv

/* Makefile */
# Verilator build and run of the board test core testbench
TOP := marble_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module $(TOP) -Mdir $(OBJ)

# Status comes from the log, not from the simulator exit code
run: compile
	-./$(OBJ)/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" sim.log; then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
